// File: hw/datapathPkg.sv
// datapath widths, register and selector enums, ALU opcodes, flag bit positions
`default_nettype none

package datapathPkg;

    localparam int DATA_W    = 8;   // datapath width
    localparam int ADDR_W    = 8;   // memory address width
    localparam int MEM_DEPTH = 256; // words in data memory
    localparam int IR_W      = 16;  // instruction register width
    localparam int NUM_GP    = 4;   // general registers R1..R4
    localparam int NUM_AR    = 3;   // PC, AR, SP

    // flag word layout {Z, C, N, O}
    localparam int FLAG_Z = 3;
    localparam int FLAG_C = 2;
    localparam int FLAG_N = 1;
    localparam int FLAG_O = 0;

    // register function, shared by every counting register
    typedef enum logic [1:0] {
        FUN_DEC   = 2'd0,
        FUN_INC   = 2'd1,
        FUN_LOAD  = 2'd2,
        FUN_CLEAR = 2'd3
    } regFun_t;

    typedef enum logic [1:0] {
        GP_R1 = 2'd0,
        GP_R2 = 2'd1,
        GP_R3 = 2'd2,
        GP_R4 = 2'd3
    } gpSel_t;

    // codes 0 and 1 both select PC
    typedef enum logic [1:0] {
        AR_PC     = 2'd0,
        AR_PC_ALT = 2'd1,
        AR_AR     = 2'd2,
        AR_SP     = 2'd3
    } arSel_t;

    typedef enum logic [3:0] {
        PASS_A, PASS_B, NOT_A, NOT_B, ADD, ADDC, SUB, AND, OR, XOR,
        LSL, LSR, ASL, ASR, ROL, ROR
    } aluOp_t;

    typedef enum logic [1:0] {
        MUXA_IR   = 2'd0,
        MUXA_MEM  = 2'd1,
        MUXA_ARFC = 2'd2,
        MUXA_ALU  = 2'd3
    } muxASel_t;

    typedef enum logic [1:0] {
        MUXB_ARFC = 2'd0,
        MUXB_IR   = 2'd1,
        MUXB_MEM  = 2'd2,
        MUXB_ALU  = 2'd3
    } muxBSel_t;

    typedef enum logic {
        MUXC_ARFC = 1'b0,
        MUXC_RFA  = 1'b1
    } muxCSel_t;

endpackage

`default_nettype wire

// File: hw/countingRegister.sv
// 8-bit register with hold, decrement, increment, load and clear
`timescale 1ns/1ps
`default_nettype none

module countingRegister
    import datapathPkg::*;
(
    input  wire logic              CLK,
    input  wire logic              rst_i,
    input  wire logic              en_i,  // one-cycle strobe
    input  wire regFun_t           fun_i,
    input  wire logic [DATA_W-1:0] d_i,
    output logic      [DATA_W-1:0] q_o
);

    always_ff @(posedge CLK) begin
        if (rst_i) begin
            q_o <= '0;
        end else if (en_i) begin
            case (fun_i)
                FUN_DEC:   q_o <= q_o - 1'b1; // wraps 00 -> ff
                FUN_INC:   q_o <= q_o + 1'b1; // wraps ff -> 00
                FUN_LOAD:  q_o <= d_i;
                FUN_CLEAR: q_o <= '0;
                default:   q_o <= q_o;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/generalRegFile.sv
// four general registers with shared write function and two read ports
`timescale 1ns/1ps
`default_nettype none

module generalRegFile
    import datapathPkg::*;
(
    input  wire logic              CLK,
    input  wire logic              rst_i,
    input  wire logic [NUM_GP-1:0] en_i,    // bit 0 is R1
    input  wire regFun_t           fun_i,
    input  wire logic [DATA_W-1:0] d_i,
    input  wire gpSel_t            selA_i,
    input  wire gpSel_t            selB_i,
    output logic      [DATA_W-1:0] outA_o,
    output logic      [DATA_W-1:0] outB_o
);

    logic [DATA_W-1:0] regQ [NUM_GP]; // R1..R4 contents

    // every enabled register applies the same function
    for (genvar i = 0; i < NUM_GP; i++) begin : gReg
        countingRegister uReg (
            .CLK   (CLK),
            .rst_i (rst_i),
            .en_i  (en_i[i]),
            .fun_i (fun_i),
            .d_i   (d_i),
            .q_o   (regQ[i])
        );
    end

    always_comb begin
        case (selA_i) // port A
            GP_R1:   outA_o = regQ[0];
            GP_R2:   outA_o = regQ[1];
            GP_R3:   outA_o = regQ[2];
            default: outA_o = regQ[3];
        endcase
    end

    always_comb begin
        case (selB_i) // port B, independent of A
            GP_R1:   outB_o = regQ[0];
            GP_R2:   outB_o = regQ[1];
            GP_R3:   outB_o = regQ[2];
            default: outB_o = regQ[3];
        endcase
    end

endmodule

`default_nettype wire

// File: hw/addressRegFile.sv
// PC, AR and SP registers with two read ports
`timescale 1ns/1ps
`default_nettype none

module addressRegFile
    import datapathPkg::*;
(
    input  wire logic              CLK,
    input  wire logic              rst_i,
    input  wire logic [NUM_AR-1:0] en_i,    // {SP, AR, PC}
    input  wire regFun_t           fun_i,
    input  wire logic [DATA_W-1:0] d_i,
    input  wire arSel_t            selC_i,
    input  wire arSel_t            selD_i,
    output logic      [DATA_W-1:0] outC_o,
    output logic      [DATA_W-1:0] outD_o
);

    logic [DATA_W-1:0] pcQ;
    logic [DATA_W-1:0] arQ;
    logic [DATA_W-1:0] spQ;

    countingRegister uPc (.CLK(CLK), .rst_i(rst_i), .en_i(en_i[0]), .fun_i(fun_i),
                          .d_i(d_i), .q_o(pcQ));
    countingRegister uAr (.CLK(CLK), .rst_i(rst_i), .en_i(en_i[1]), .fun_i(fun_i),
                          .d_i(d_i), .q_o(arQ));
    countingRegister uSp (.CLK(CLK), .rst_i(rst_i), .en_i(en_i[2]), .fun_i(fun_i),
                          .d_i(d_i), .q_o(spQ));

    always_comb begin
        case (selC_i)
            AR_AR:   outC_o = arQ;
            AR_SP:   outC_o = spQ;
            default: outC_o = pcQ; // AR_PC and AR_PC_ALT
        endcase
    end

    // port D drives the memory address
    always_comb begin
        case (selD_i)
            AR_AR:   outD_o = arQ;
            AR_SP:   outD_o = spQ;
            default: outD_o = pcQ;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/instructionRegister.sv
// 16-bit instruction register with byte-half load and whole-word count and clear
`timescale 1ns/1ps
`default_nettype none

module instructionRegister
    import datapathPkg::*;
(
    input  wire logic              CLK,
    input  wire logic              rst_i,
    input  wire logic              en_i,
    input  wire logic              lowHalf_i, // 0 loads 15:8, 1 loads 7:0
    input  wire regFun_t           fun_i,
    input  wire logic [DATA_W-1:0] d_i,       // byte from memory
    output logic      [IR_W-1:0]   ir_o
);

    always_ff @(posedge CLK) begin
        if (rst_i) begin
            ir_o <= '0;
        end else if (en_i) begin
            case (fun_i)
                FUN_DEC:   ir_o <= ir_o - 1'b1; // whole word
                FUN_INC:   ir_o <= ir_o + 1'b1;
                FUN_LOAD: begin
                    // other half is kept
                    if (lowHalf_i) begin
                        ir_o[DATA_W-1:0] <= d_i;
                    end else begin
                        ir_o[IR_W-1:DATA_W] <= d_i;
                    end
                end
                FUN_CLEAR: ir_o <= '0;
                default:   ir_o <= ir_o;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/arithLogicUnit.sv
// combinational 16-function ALU with registered Z, C, N, O flags
`timescale 1ns/1ps
`default_nettype none

module arithLogicUnit
    import datapathPkg::*;
(
    input  wire logic              CLK,
    input  wire logic              rst_i,
    input  wire aluOp_t            op_i,
    input  wire logic [DATA_W-1:0] a_i,
    input  wire logic [DATA_W-1:0] b_i,
    output logic      [DATA_W-1:0] result_o,
    output logic      [3:0]        flags_o
);

    logic [3:0]      flagQ;   // {Z, C, N, O}
    logic            cIn;     // stored carry
    logic [DATA_W:0] sumFull; // carry or borrow in the top bit
    logic            cNext;
    logic            oNext;

    assign cIn     = flagQ[FLAG_C];
    assign flags_o = flagQ;

    always_comb begin
        result_o = '0;
        sumFull  = '0;
        cNext    = flagQ[FLAG_C]; // hold unless the op sets it
        oNext    = flagQ[FLAG_O];
        case (op_i)
            PASS_A: result_o = a_i;
            PASS_B: result_o = b_i;
            NOT_A:  result_o = ~a_i;
            NOT_B:  result_o = ~b_i;
            ADD, ADDC: begin
                sumFull = {1'b0, a_i} + {1'b0, b_i};
                if (op_i == ADDC) begin
                    sumFull = sumFull + {{DATA_W{1'b0}}, cIn}; // carry in
                end
                result_o = sumFull[DATA_W-1:0];
                cNext    = sumFull[DATA_W];
                // same-sign operands, result sign differs
                oNext    = (a_i[DATA_W-1] == b_i[DATA_W-1]) &&
                           (result_o[DATA_W-1] != a_i[DATA_W-1]);
            end
            SUB: begin
                sumFull  = {1'b0, a_i} - {1'b0, b_i};
                result_o = sumFull[DATA_W-1:0];
                cNext    = sumFull[DATA_W]; // borrow when a < b
                oNext    = (a_i[DATA_W-1] != b_i[DATA_W-1]) &&
                           (result_o[DATA_W-1] != a_i[DATA_W-1]);
            end
            AND: result_o = a_i & b_i;
            OR:  result_o = a_i | b_i;
            XOR: result_o = a_i ^ b_i;
            LSL: begin
                result_o = {a_i[DATA_W-2:0], 1'b0};
                cNext    = a_i[DATA_W-1];
            end
            LSR: begin
                result_o = {1'b0, a_i[DATA_W-1:1]};
                cNext    = a_i[0];
            end
            ASL: begin
                result_o = {a_i[DATA_W-2:0], 1'b0};
                cNext    = a_i[DATA_W-1];
                oNext    = a_i[DATA_W-1] ^ a_i[DATA_W-2]; // sign bit changes
            end
            ASR: begin
                result_o = {a_i[DATA_W-1], a_i[DATA_W-1:1]}; // sign kept
                cNext    = a_i[0];
            end
            ROL: begin
                result_o = {a_i[DATA_W-2:0], cIn}; // through carry
                cNext    = a_i[DATA_W-1];
            end
            ROR: begin
                result_o = {cIn, a_i[DATA_W-1:1]};
                cNext    = a_i[0];
            end
            default: result_o = '0;
        endcase
    end

    // flags register every cycle, Z and N always track the result
    always_ff @(posedge CLK) begin
        if (rst_i) begin
            flagQ <= '0;
        end else begin
            flagQ[FLAG_Z] <= (result_o == '0);
            flagQ[FLAG_C] <= cNext;
            flagQ[FLAG_N] <= result_o[DATA_W-1];
            flagQ[FLAG_O] <= oNext;
        end
    end

endmodule

`default_nettype wire

// File: hw/dataMemory.sv
// 256-byte data memory, synchronous write and combinational read
`timescale 1ns/1ps
`default_nettype none

module dataMemory
    import datapathPkg::*;
(
    input  wire logic              CLK,
    input  wire logic              en_i,
    input  wire logic              write_i,
    input  wire logic [ADDR_W-1:0] addr_i,
    input  wire logic [DATA_W-1:0] wdata_i,
    output logic      [DATA_W-1:0] rdata_o
);

    logic [DATA_W-1:0] mem [MEM_DEPTH]; // contents undefined until written

    always_ff @(posedge CLK) begin
        if (en_i && write_i) begin
            mem[addr_i] <= wdata_i;
        end
    end

    // zero when disabled or writing
    assign rdata_o = (en_i && !write_i) ? mem[addr_i] : '0;

endmodule

`default_nettype wire

// File: hw/aluSystem.sv
// top-level datapath with register files, IR, ALU, memory and source multiplexers
`timescale 1ns/1ps
`default_nettype none

module aluSystem
    import datapathPkg::*;
(
    input  wire logic              CLK,
    input  wire logic              rst_i,
    input  wire gpSel_t            rfSelA_i,
    input  wire gpSel_t            rfSelB_i,
    input  wire regFun_t           rfFun_i,
    input  wire logic [NUM_GP-1:0] rfEn_i,
    input  wire aluOp_t            aluOp_i,
    input  wire arSel_t            arfSelC_i,
    input  wire arSel_t            arfSelD_i,
    input  wire regFun_t           arfFun_i,
    input  wire logic [NUM_AR-1:0] arfEn_i,
    input  wire logic              irLowHalf_i,
    input  wire logic              irEn_i,
    input  wire regFun_t           irFun_i,
    input  wire logic              memWrite_i,
    input  wire logic              memEn_i,
    input  wire muxASel_t          muxASel_i,
    input  wire muxBSel_t          muxBSel_i,
    input  wire muxCSel_t          muxCSel_i,
    output logic      [DATA_W-1:0] aluResult_o,
    output logic      [3:0]        aluFlags_o,
    output logic      [ADDR_W-1:0] address_o,
    output logic      [DATA_W-1:0] memData_o,
    output logic      [IR_W-1:0]   ir_o,
    output logic      [DATA_W-1:0] rfOutA_o,
    output logic      [DATA_W-1:0] rfOutB_o
);

    logic [DATA_W-1:0] arfOutC;
    logic [DATA_W-1:0] muxAOut; // general file input
    logic [DATA_W-1:0] muxBOut; // address file input
    logic [DATA_W-1:0] muxCOut; // ALU A operand

    always_comb begin
        case (muxASel_i)
            MUXA_IR:   muxAOut = ir_o[DATA_W-1:0]; // IR low byte
            MUXA_MEM:  muxAOut = memData_o;
            MUXA_ARFC: muxAOut = arfOutC;
            default:   muxAOut = aluResult_o;
        endcase
    end

    always_comb begin
        case (muxBSel_i)
            MUXB_ARFC: muxBOut = arfOutC;
            MUXB_IR:   muxBOut = ir_o[DATA_W-1:0];
            MUXB_MEM:  muxBOut = memData_o;
            default:   muxBOut = aluResult_o;
        endcase
    end

    assign muxCOut = (muxCSel_i == MUXC_RFA) ? rfOutA_o : arfOutC;

    generalRegFile uRf (.CLK(CLK), .rst_i(rst_i), .en_i(rfEn_i), .fun_i(rfFun_i),
                        .d_i(muxAOut), .selA_i(rfSelA_i), .selB_i(rfSelB_i),
                        .outA_o(rfOutA_o), .outB_o(rfOutB_o));

    addressRegFile uArf (.CLK(CLK), .rst_i(rst_i), .en_i(arfEn_i), .fun_i(arfFun_i),
                         .d_i(muxBOut), .selC_i(arfSelC_i), .selD_i(arfSelD_i),
                         .outC_o(arfOutC), .outD_o(address_o)); // port D addresses memory

    instructionRegister uIr (.CLK(CLK), .rst_i(rst_i), .en_i(irEn_i),
                             .lowHalf_i(irLowHalf_i), .fun_i(irFun_i),
                             .d_i(memData_o), .ir_o(ir_o));

    arithLogicUnit uAlu (.CLK(CLK), .rst_i(rst_i), .op_i(aluOp_i), .a_i(muxCOut),
                         .b_i(rfOutB_o), .result_o(aluResult_o), .flags_o(aluFlags_o));

    // ALU result is the only write-data source
    dataMemory uMem (.CLK(CLK), .en_i(memEn_i), .write_i(memWrite_i), .addr_i(address_o),
                     .wdata_i(aluResult_o), .rdata_o(memData_o));

endmodule

`default_nettype wire

// File: verification/datapathModel.svh
// reference model state, register and IR update functions, address register read
`ifndef DATAPATH_MODEL_SVH
`define DATAPATH_MODEL_SVH

logic [DATA_W-1:0] gpModel [NUM_GP];       // R1..R4
logic [DATA_W-1:0] arModel [NUM_AR];       // PC, AR, SP
logic [IR_W-1:0]   irModel;
logic [3:0]        flagModel;              // {Z, C, N, O}
logic [DATA_W-1:0] memModel [MEM_DEPTH];
logic              memWritten [MEM_DEPTH]; // set once an address holds known data

task automatic resetModel();
    for (int i = 0; i < NUM_GP; i++) gpModel[i] = '0;
    for (int i = 0; i < NUM_AR; i++) arModel[i] = '0;
    irModel   = '0;
    flagModel = '0;
    for (int m = 0; m < MEM_DEPTH; m++) memWritten[m] = 1'b0; // contents unknown
endtask

// one counting register step with wraparound
function automatic logic [DATA_W-1:0] nextCount(regFun_t fun, logic [DATA_W-1:0] q,
                                                logic [DATA_W-1:0] d);
    case (fun)
        FUN_DEC:  return q + {DATA_W{1'b1}}; // adding all ones subtracts one
        FUN_INC:  return q + DATA_W'(1);
        FUN_LOAD: return d;
        default:  return '0;
    endcase
endfunction

// byte load into one half, count and clear on the whole word
function automatic logic [IR_W-1:0] nextIr(regFun_t fun, logic lowHalf, logic [IR_W-1:0] ir,
                                           logic [DATA_W-1:0] d);
    case (fun)
        FUN_DEC:  return ir - IR_W'(1);
        FUN_INC:  return ir + IR_W'(1);
        FUN_LOAD: return lowHalf ? {ir[IR_W-1:DATA_W], d} : {d, ir[DATA_W-1:0]};
        default:  return '0;
    endcase
endfunction

function automatic logic [DATA_W-1:0] readAddrReg(arSel_t sel);
    case (sel)
        AR_AR:   return arModel[1];
        AR_SP:   return arModel[2];
        default: return arModel[0]; // both PC codes
    endcase
endfunction

`endif

// File: verification/aluSystemTb.sv
// testbench for aluSystem with random control stimulus checked against a reference model
`timescale 1ns/1ps
`default_nettype none

module aluSystemTb
    import datapathPkg::*;
;

    localparam int RESET_CYCLES  = 2;
    localparam int IDLE_CYCLES   = 4;   // reset values seen on every selector
    localparam int RANDOM_CYCLES = 600;
    localparam int CYCLE_LIMIT   = RESET_CYCLES + IDLE_CYCLES + MEM_DEPTH + RANDOM_CYCLES + 50;

    logic CLK = 1'b0;
    logic rst;
    int   seed;
    int   cycleCount = 0;

    gpSel_t            rfSelA, rfSelB;
    regFun_t           rfFun, arfFun, irFun;
    logic [NUM_GP-1:0] rfEn;
    aluOp_t            aluOp;
    arSel_t            arfSelC, arfSelD;
    logic [NUM_AR-1:0] arfEn;
    logic              irLowHalf, irEn, memWrite, memEn;
    muxASel_t          muxASel;
    muxBSel_t          muxBSel;
    muxCSel_t          muxCSel;

    logic [DATA_W-1:0] aluResult, memData, rfOutA, rfOutB;
    logic [ADDR_W-1:0] address;
    logic [3:0]        aluFlags;
    logic [IR_W-1:0]   irOut;

    `include "datapathModel.svh"

    aluSystem dut0 (
        .CLK(CLK), .rst_i(rst),
        .rfSelA_i(rfSelA), .rfSelB_i(rfSelB), .rfFun_i(rfFun), .rfEn_i(rfEn),
        .aluOp_i(aluOp),
        .arfSelC_i(arfSelC), .arfSelD_i(arfSelD), .arfFun_i(arfFun), .arfEn_i(arfEn),
        .irLowHalf_i(irLowHalf), .irEn_i(irEn), .irFun_i(irFun),
        .memWrite_i(memWrite), .memEn_i(memEn),
        .muxASel_i(muxASel), .muxBSel_i(muxBSel), .muxCSel_i(muxCSel),
        .aluResult_o(aluResult), .aluFlags_o(aluFlags), .address_o(address),
        .memData_o(memData), .ir_o(irOut), .rfOutA_o(rfOutA), .rfOutB_o(rfOutB)
    );

    always #50 CLK = ~CLK; // 100 ns period

    task automatic stopWithFailure(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    always @(posedge CLK) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount > CYCLE_LIMIT) begin
            stopWithFailure("timeout, the run went past its cycle limit");
        end
    end

    task automatic checkData(input string name, input logic [DATA_W-1:0] expVal,
                             input logic [DATA_W-1:0] actVal);
        if (actVal !== expVal) begin
            stopWithFailure($sformatf("Error %s expected %h actual %h", name, expVal, actVal));
        end
    endtask

    task automatic checkFlags(input logic [3:0] expVal, input logic [3:0] actVal);
        if (actVal !== expVal) begin
            stopWithFailure($sformatf("Error aluFlags_o expected %h actual %h", expVal, actVal));
        end
    endtask

    task automatic checkIr(input logic [IR_W-1:0] expVal, input logic [IR_W-1:0] actVal);
        if (actVal !== expVal) begin
            stopWithFailure($sformatf("Error ir_o expected %h actual %h", expVal, actVal));
        end
    endtask

    // expected ALU result and the flags it leaves after the edge
    task automatic computeAlu(input aluOp_t op, input logic [DATA_W-1:0] a,
                              input logic [DATA_W-1:0] b, input logic [3:0] flagsIn,
                              output logic [DATA_W-1:0] res, output logic [3:0] flagsOut);
        int   uSum;
        int   sSum;
        int   cIn;
        logic cy;
        logic ov;
        cIn  = int'(flagsIn[FLAG_C]);
        cy   = flagsIn[FLAG_C]; // C and O hold by default
        ov   = flagsIn[FLAG_O];
        uSum = 0;
        sSum = 0;
        res  = '0;
        case (op)
            PASS_A: res = a;
            PASS_B: res = b;
            NOT_A:  res = a ^ {DATA_W{1'b1}};
            NOT_B:  res = b ^ {DATA_W{1'b1}};
            ADD, ADDC: begin
                uSum = int'(a) + int'(b) + ((op == ADDC) ? cIn : 0);
                sSum = int'($signed(a)) + int'($signed(b)) + ((op == ADDC) ? cIn : 0);
                res  = uSum[DATA_W-1:0];
                cy   = (uSum >= (1 << DATA_W));
                ov   = (sSum > (1 << (DATA_W-1)) - 1) || (sSum < -(1 << (DATA_W-1)));
            end
            SUB: begin
                sSum = int'($signed(a)) - int'($signed(b));
                res  = a - b;
                cy   = (a < b); // borrow
                ov   = (sSum > (1 << (DATA_W-1)) - 1) || (sSum < -(1 << (DATA_W-1)));
            end
            AND: res = a & b;
            OR:  res = a | b;
            XOR: res = a ^ b;
            LSL: begin
                res = a << 1;
                cy  = a[DATA_W-1];
            end
            LSR: begin
                res = a >> 1;
                cy  = a[0];
            end
            ASL: begin
                res = a << 1;
                cy  = a[DATA_W-1];
                ov  = (res[DATA_W-1] != a[DATA_W-1]);
            end
            ASR: begin
                res = $signed(a) >>> 1;
                cy  = a[0];
            end
            ROL: begin
                res = {a[DATA_W-2:0], flagsIn[FLAG_C]};
                cy  = a[DATA_W-1];
            end
            ROR: begin
                res = {flagsIn[FLAG_C], a[DATA_W-1:1]};
                cy  = a[0];
            end
            default: res = '0;
        endcase
        flagsOut[FLAG_Z] = (res == '0);
        flagsOut[FLAG_C] = cy;
        flagsOut[FLAG_N] = res[DATA_W-1];
        flagsOut[FLAG_O] = ov;
    endtask

    task automatic driveIdle();
        rfSelA    = GP_R1;
        rfSelB    = GP_R1;
        rfFun     = FUN_DEC;
        rfEn      = '0;
        aluOp     = PASS_A;
        arfSelC   = AR_PC;
        arfSelD   = AR_PC;
        arfFun    = FUN_DEC;
        arfEn     = '0;
        irLowHalf = 1'b0;
        irEn      = 1'b0;
        irFun     = FUN_DEC;
        memWrite  = 1'b0;
        memEn     = 1'b0;
        muxASel   = MUXA_IR;
        muxBSel   = MUXB_ARFC;
        muxCSel   = MUXC_ARFC;
    endtask

    task automatic driveRandom();
        logic [31:0] r;
        r = $random(seed);
        rfSelA    = gpSel_t'(r[1:0]);
        rfSelB    = gpSel_t'(r[3:2]);
        rfFun     = regFun_t'(r[5:4]);
        rfEn      = r[9:6];
        aluOp     = aluOp_t'(r[13:10]);
        arfSelC   = arSel_t'(r[15:14]);
        arfSelD   = arSel_t'(r[17:16]);
        arfFun    = regFun_t'(r[19:18]);
        arfEn     = r[22:20];
        irLowHalf = r[23];
        irEn      = r[24];
        irFun     = regFun_t'(r[26:25]);
        r = $random(seed);
        memEn     = r[0] | r[1];           // mostly enabled
        memWrite  = (r[3:2] == 2'b00);     // about one write in four
        muxASel   = muxASel_t'(r[5:4]);
        muxBSel   = muxBSel_t'(r[7:6]);
        muxCSel   = muxCSel_t'(r[8]);
    endtask

    // fill memory with pass-B data while AR steps through every address
    task automatic driveSweep();
        driveRandom();
        aluOp    = PASS_B;
        arfSelD  = AR_AR;
        arfEn    = 3'b010;
        arfFun   = FUN_INC;
        memEn    = 1'b1;
        memWrite = 1'b1;
        irEn     = 1'b0;
    endtask

    // check outputs just before the edge, then step the model past it
    task automatic checkAndStep();
        logic [DATA_W-1:0] expA, expB, expC, expD, expMem, expAlu, srcA, srcB;
        logic [3:0]        nextFlags;
        logic              memKnown;
        #80;
        expA     = gpModel[rfSelA];
        expB     = gpModel[rfSelB];
        expC     = readAddrReg(arfSelC);
        expD     = readAddrReg(arfSelD);
        memKnown = 1'b1;
        expMem   = '0; // disabled or writing
        if (memEn && !memWrite) begin
            memKnown = memWritten[expD];
            expMem   = memModel[expD];
        end
        computeAlu(aluOp, (muxCSel == MUXC_RFA) ? expA : expC, expB, flagModel,
                   expAlu, nextFlags);
        checkData("rfOutA_o", expA, rfOutA);
        checkData("rfOutB_o", expB, rfOutB);
        checkData("address_o", expD, address);
        if (memKnown) checkData("memData_o", expMem, memData);
        checkData("aluResult_o", expAlu, aluResult);
        checkFlags(flagModel, aluFlags);
        checkIr(irModel, irOut);
        case (muxASel)
            MUXA_IR:   srcA = irModel[DATA_W-1:0];
            MUXA_MEM:  srcA = expMem;
            MUXA_ARFC: srcA = expC;
            default:   srcA = expAlu;
        endcase
        case (muxBSel)
            MUXB_ARFC: srcB = expC;
            MUXB_IR:   srcB = irModel[DATA_W-1:0];
            MUXB_MEM:  srcB = expMem;
            default:   srcB = expAlu;
        endcase
        for (int i = 0; i < NUM_GP; i++) begin
            if (rfEn[i]) gpModel[i] = nextCount(rfFun, gpModel[i], srcA);
        end
        for (int i = 0; i < NUM_AR; i++) begin
            if (arfEn[i]) arModel[i] = nextCount(arfFun, arModel[i], srcB);
        end
        if (irEn) irModel = nextIr(irFun, irLowHalf, irModel, expMem);
        if (memEn && memWrite) begin
            memModel[expD]   = expAlu; // ALU result is the write data
            memWritten[expD] = 1'b1;
        end
        flagModel = nextFlags;
        @(posedge CLK);
        #5;
    endtask

    initial begin
        seed = 32'he06ad875;
        driveIdle();
        rst = 1'b1;
        resetModel();
        repeat (RESET_CYCLES) @(posedge CLK);
        #5;
        rst = 1'b0;
        for (int i = 0; i < IDLE_CYCLES; i++) begin
            driveIdle();
            rfSelA  = gpSel_t'(i[1:0]);
            rfSelB  = gpSel_t'(~i[1:0]);
            arfSelC = arSel_t'(i[1:0]);
            arfSelD = arSel_t'(~i[1:0]);
            checkAndStep();
        end
        for (int i = 0; i < MEM_DEPTH; i++) begin
            driveSweep();
            checkAndStep();
        end
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            driveRandom();
            checkAndStep();
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// File: aluSystem.f
+incdir+verification
hw/datapathPkg.sv
hw/countingRegister.sv
hw/generalRegFile.sv
hw/addressRegFile.sv
hw/instructionRegister.sv
hw/arithLogicUnit.sv
hw/dataMemory.sv
hw/aluSystem.sv
verification/aluSystemTb.sv

// File: run.sh
#!/bin/sh
# compile the testbench with Verilator, then run it; a $fatal gives a failing status
verilator --binary --timing -Wno-fatal -f aluSystem.f --top-module aluSystemTb \
    -o aluSystemSim \
    && ./obj_dir/aluSystemSim \
    || { echo "simulation did not pass"; exit 1; }
